/* tb/programPatterns.txt */
// Records of four hex words: kind address value byteEn
// Kind 1 is an instruction word (byteEn 0), kind 2 an expected store, kind 0 ends the list
1 000 000010b7 0  1 004 01900113 0  1 008 ff900193 0  1 00c 00310233 0
1 010 403102b3 0  1 014 00411313 0  1 018 4021d393 0  1 01c 01c1d413 0
1 020 0021a4b3 0  1 024 0021b533 0  1 028 003145b3 0  1 02c 00316633 0
1 030 003176b3 0  1 034 0040a023 0  1 038 0050a223 0  1 03c 0060a423 0
1 040 0070a623 0  1 044 0080a823 0  1 048 0090aa23 0  1 04c 00a0ac23 0
1 050 00b0ae23 0  1 054 02c0a023 0  1 058 02d0a223 0  1 05c 0000006f 0
2 1000 00000012 f  2 1004 00000020 f  2 1008 00000190 f  2 100c fffffffe f
2 1010 0000000f f  2 1014 00000001 f  2 1018 00000000 f  2 101c ffffffe0 f
2 1020 fffffff9 f  2 1024 00000019 f
1 100 000010b7 0  1 104 10008093 0  1 108 00500113 0  1 10c ffd00193 0
1 110 00000213 0  1 114 00000293 0  1 118 00210463 0  1 11c 00128293 0
1 120 00311463 0  1 124 00128293 0  1 128 0021c463 0  1 12c 00128293 0
1 130 00315463 0  1 134 00128293 0  1 138 00316463 0  1 13c 00128293 0
1 140 0021f463 0  1 144 00128293 0  1 148 00310463 0  1 14c 00120213 0
1 150 00211463 0  1 154 00120213 0  1 158 00314463 0  1 15c 00120213 0
1 160 0021d463 0  1 164 00120213 0  1 168 0021e463 0  1 16c 00120213 0
1 170 00317463 0  1 174 00120213 0  1 178 0080036f 0  1 17c 0220ae23 0
1 180 00c303e7 0  1 184 0220ae23 0  1 188 0040a023 0  1 18c 0050a223 0
1 190 0060a423 0  1 194 0070a623 0  1 198 0000006f 0
2 1100 00000006 f  2 1104 00000000 f  2 1108 0000017c f  2 110c 00000184 f
1 200 000010b7 0  1 204 20008093 0  1 208 12345137 0  1 20c 67810113 0
1 210 00208023 0  1 214 00209223 0  1 218 0020a423 0  1 21c 0000a183 0
1 220 0040a203 0  1 224 0080a283 0  1 228 0030a623 0  1 22c 0040a823 0
1 230 0050aa23 0  1 234 00001317 0  1 238 0060ac23 0  1 23c abcde3b7 0
1 240 0070ae23 0  1 244 0000006f 0
2 1200 00000078 1  2 1204 00005678 3  2 1208 12345678 f  2 120c 00000078 f
2 1210 00005678 f  2 1214 12345678 f  2 1218 00001234 f  2 121c abcde000 f
1 300 000010b7 0  1 304 30008093 0  1 308 33300113 0  1 30c f9c00193 0
1 310 03700013 0  1 314 0020a023 0  1 318 0030a223 0  1 31c 0000a423 0
1 320 0000006f 0
2 1300 00000333 f  2 1304 ffffff9c f  2 1308 00000000 f
0 0 0 0

/* verilog.f */
source/corePkg.sv
source/threadScheduler.sv
source/decodeUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/branchCompare.sv
source/executeStage.sv
source/memWriteback.sv
source/coreTop.sv
tb/tbClock.sv
tb/coreTopTb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
verilator --binary --timing -f verilog.f --top-module coreTopTb -o simv > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "=== PASS ===" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb/coreTopTb.sv */
`timescale 1ns/1ps

module coreTopTb;
    import corePkg::*;

    localparam int PcStride = 256;
    localparam int PatDepth = 1024;

    // Fetch PCs of threads 0 to 3 right after reset
    localparam tWord ResetPcs [NumThreads] = '{
        32'h0000_0000, 32'h0000_0100, 32'h0000_0200, 32'h0000_0300
    };

    logic   QClk;
    logic   arstN;
    tWord   pcQ100H;
    tWord   instQ101H;
    tMemReq memReqQ103H;
    tWord   memRdDataQ104H;

    logic [31:0] patWords [0:PatDepth-1]; // Flat records of four words
    tWord        instMem [tWord];          // Program image
    logic [7:0]  dataMem [tWord];          // Byte addressed data memory
    tWord        expAddr [$];
    tWord        expData [$];
    logic [3:0]  expBe [$];
    bit          expSeen [$];
    int          errCount [1:5];
    int          numInstr = 0;
    int          timeoutLimit = 0;
    int          cycleCount = 0;

    tbClock #(.PeriodNs(20), .ResetCycles(8)) tbClock_inst (.QClk(QClk), .arstN(arstN));

    coreTop #(.ThreadPcStride(PcStride)) coreTop_inst (
        .QClk(QClk), .arstN(arstN),
        .pcQ100H(pcQ100H), .instQ101H(instQ101H),
        .memReqQ103H(memReqQ103H), .memRdDataQ104H(memRdDataQ104H)
    );

    ////////////////////
    // Helpers
    ////////////////////
    task automatic checkValue(input int testNum, input string what, input tWord actual,
                              input tWord expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            errCount[testNum]++;
        end
    endtask

    function automatic string testLabel(input int n);
        case (n)
            1:       return "reset and rotation";
            2:       return "arithmetic";
            3:       return "control flow";
            4:       return "memory widths";
            default: return "thread isolation and x0";
        endcase
    endfunction

    function automatic tWord byteMask(input logic [3:0] be);
        tWord mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = be[b] ? 8'hff : 8'h00;
        end
        return mask;
    endfunction

    // Unwritten bytes read as zero
    function automatic tWord readWord(input tWord addr);
        tWord word;
        for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = dataMem.exists(addr + b) ? dataMem[addr + b] : 8'h00;
        end
        return word;
    endfunction

    function automatic int missingStores();
        int n;
        n = 0;
        foreach (expSeen[i]) begin
            if (!expSeen[i]) n++;
        end
        return n;
    endfunction

    // Match the first open record for this address in program order
    task automatic checkStore(input tMemReq req);
        int idx;
        int testNum;
        idx     = -1;
        testNum = 2 + int'(req.addr[9:8]); // Data window picks the thread
        foreach (expAddr[i]) begin
            if (idx < 0 && !expSeen[i] && expAddr[i] == req.addr) idx = i;
        end
        if (idx < 0) begin
            $display("Unexpected store of %h to address %h at time %0t",
                     req.wrData, req.addr, $time);
            errCount[testNum]++;
        end else begin
            expSeen[idx] = 1'b1;
            checkValue(testNum, "store byte enable", 32'(req.byteEn), 32'(expBe[idx]));
            checkValue(testNum, "store data", req.wrData & byteMask(req.byteEn), expData[idx]);
        end
    endtask

    task automatic reportTest(input int n);
        $display("Test %0d (%s): %s, %0d errors", n, testLabel(n),
                 (errCount[n] == 0) ? "passed" : "failed", errCount[n]);
    endtask

    ////////////////////
    // Memory models
    ////////////////////
    always @(posedge QClk) begin
        instQ101H <= instMem.exists(pcQ100H) ? instMem[pcQ100H] : NopWord; // One cycle
        if (memReqQ103H.rd) begin
            memRdDataQ104H <= readWord(memReqQ103H.addr);
        end
        if (arstN && memReqQ103H.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (memReqQ103H.byteEn[b]) begin
                    dataMem[memReqQ103H.addr + b] = memReqQ103H.wrData[8*b +: 8];
                end
            end
            checkStore(memReqQ103H);
        end
    end

    // Run limit from program length
    always @(posedge QClk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles with %0d expected stores never seen",
                     cycleCount, missingStores());
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // Sequence
    ////////////////////
    initial begin
        int idx;
        int failedTests;
        int totalErrors;
        instQ101H      <= NopWord;
        memRdDataQ104H <= '0;
        for (int n = 1; n <= 5; n++) errCount[n] = 0;
        for (int i = 0; i < PatDepth; i++) patWords[i] = '0;
        $readmemh("tb/programPatterns.txt", patWords);

        // Kind 1 is a program word, kind 2 an expected store, kind 0 ends the list
        idx = 0;
        while (idx + 3 < PatDepth && patWords[idx] != 0) begin
            case (patWords[idx])
                1: begin
                    instMem[patWords[idx+1]] = patWords[idx+2];
                    numInstr++;
                end
                2: begin
                    expAddr.push_back(patWords[idx+1]);
                    expData.push_back(patWords[idx+2]);
                    expBe.push_back(patWords[idx+3][3:0]);
                    expSeen.push_back(1'b0);
                end
                default: begin
                    $display("Pattern file holds an unknown record kind at word %0d", idx);
                    errCount[1]++;
                end
            endcase
            idx += 4;
        end
        if (numInstr == 0) begin
            $display("Pattern file holds no program words");
            errCount[1]++;
        end
        timeoutLimit = 40 * numInstr + 100;

        // Test 1 checks the request flags under reset
        @(negedge QClk);
        while (!arstN) begin
            checkValue(1, "request rd during reset", 32'(memReqQ103H.rd), 32'd0);
            checkValue(1, "request wr during reset", 32'(memReqQ103H.wr), 32'd0);
            @(negedge QClk);
        end
        for (int t = 0; t < NumThreads; t++) begin
            checkValue(1, "fetch PC after reset", pcQ100H, ResetPcs[t]); // Ring order
            @(negedge QClk);
        end
        reportTest(1);

        // Tests 2 to 5 end when every store record is seen
        while (missingStores() > 0) @(negedge QClk);
        for (int n = 2; n <= 5; n++) reportTest(n);

        failedTests = 0;
        totalErrors = 0;
        for (int n = 1; n <= 5; n++) begin
            if (errCount[n] != 0) failedTests++;
            totalErrors += errCount[n];
        end
        $display("Summary: 5 tests, %0d passed, %0d failed, %0d errors",
                 5 - failedTests, failedTests, totalErrors);
        if (totalErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 8
) (
    output logic QClk,
    output logic arstN
);
    // Free running clock
    initial begin
        QClk = 1'b0;
        forever #(PeriodNs / 2) QClk = ~QClk;
    end

    initial begin
        arstN = 1'b0;                       // Reset held from time zero
        repeat (ResetCycles) @(posedge QClk);
        arstN <= 1'b1;                      // Release on a rising edge
    end

endmodule

/* source/coreTop.sv */
`timescale 1ns/1ps

module coreTop #(
    parameter int ThreadPcStride = 256
) (
    input  logic            QClk,
    input  logic            arstN,
    // Instruction memory
    output corePkg::tWord   pcQ100H,
    input  corePkg::tWord   instQ101H,
    // Data memory
    output corePkg::tMemReq memReqQ103H,
    input  corePkg::tWord   memRdDataQ104H
);
    import corePkg::*;

    tThreadSel threadQ100H;
    tWord      nextPcQ102H;
    tRegAddr   rs1Q101H;
    tRegAddr   rs2Q101H;
    tWord      rs1DataQ101H;
    tWord      rs2DataQ101H;
    tExecIn    execQ102H;
    tMemOp     memOpQ103H;
    tRegWrite  regWriteQ104H;

    ////////////////////
    // Fetch
    ////////////////////
    threadScheduler #(.ThreadPcStride(ThreadPcStride)) threadScheduler_inst (
        .QClk(QClk), .arstN(arstN),
        .nextPcQ102H(nextPcQ102H), .threadQ100H(threadQ100H), .pcQ100H(pcQ100H)
    );

    // Decode and register read
    decodeUnit decodeUnit_inst (
        .QClk(QClk), .arstN(arstN),
        .instQ101H(instQ101H), .pcQ100H(pcQ100H),
        .rs1DataQ101H(rs1DataQ101H), .rs2DataQ101H(rs2DataQ101H),
        .rs1Q101H(rs1Q101H), .rs2Q101H(rs2Q101H), .execQ102H(execQ102H)
    );

    registerFile registerFile_inst (
        .QClk(QClk), .arstN(arstN),
        .threadQ100H(threadQ100H), .rs1Q101H(rs1Q101H), .rs2Q101H(rs2Q101H),
        .regWriteQ104H(regWriteQ104H),
        .rs1DataQ101H(rs1DataQ101H), .rs2DataQ101H(rs2DataQ101H)
    );

    ////////////////////
    // Execute to writeback
    ////////////////////
    executeStage executeStage_inst (
        .QClk(QClk), .arstN(arstN),
        .execQ102H(execQ102H), .nextPcQ102H(nextPcQ102H), .memOpQ103H(memOpQ103H)
    );

    memWriteback memWriteback_inst (
        .QClk(QClk), .arstN(arstN),
        .memOpQ103H(memOpQ103H), .memRdDataQ104H(memRdDataQ104H),
        .memReqQ103H(memReqQ103H), .regWriteQ104H(regWriteQ104H)
    );

endmodule

/* source/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback (
    input  logic              QClk,
    input  logic              arstN,
    input  corePkg::tMemOp    memOpQ103H,
    input  corePkg::tWord     memRdDataQ104H,
    output corePkg::tMemReq   memReqQ103H,
    output corePkg::tRegWrite regWriteQ104H
);
    import corePkg::*;

    logic [3:0] byteEn;
    logic       regWrQ104H;
    logic       memToRegQ104H;
    logic       pcToRegQ104H;
    tRegAddr    rdQ104H;
    tWord       aluOutQ104H;
    tWord       pcPlus4Q104H;

    ////////////////////
    // Data memory request
    ////////////////////
    always_comb begin
        case (memOpQ103H.funct3[1:0])
            2'b00:   byteEn = 4'b0001; // Byte
            2'b01:   byteEn = 4'b0011; // Half
            2'b10:   byteEn = 4'b1111; // Word
            default: byteEn = 4'b0000;
        endcase
    end

    assign memReqQ103H = '{addr: memOpQ103H.aluOut, wrData: memOpQ103H.wrData,
                           rd: memOpQ103H.ctrl.memRd, wr: memOpQ103H.ctrl.memWr, byteEn: byteEn};

    // Q103H to Q104H, flags reset
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            regWrQ104H    <= 1'b0;
            memToRegQ104H <= 1'b0;
            pcToRegQ104H  <= 1'b0;
        end else begin
            regWrQ104H    <= memOpQ103H.ctrl.regWr;
            memToRegQ104H <= memOpQ103H.ctrl.memToReg;
            pcToRegQ104H  <= memOpQ103H.ctrl.pcToReg;
        end
    end

    always_ff @(posedge QClk) begin
        rdQ104H      <= memOpQ103H.rd;
        aluOutQ104H  <= memOpQ103H.aluOut;
        pcPlus4Q104H <= memOpQ103H.pcPlus4;
    end

    // Writeback select
    assign regWriteQ104H.en   = regWrQ104H;
    assign regWriteQ104H.idx  = rdQ104H;
    assign regWriteQ104H.data = memToRegQ104H ? memRdDataQ104H :   // Load
                                pcToRegQ104H  ? pcPlus4Q104H   :   // Link
                                                aluOutQ104H;

endmodule

/* source/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic            QClk,
    input  logic            arstN,
    input  corePkg::tExecIn execQ102H,
    output corePkg::tWord   nextPcQ102H,
    output corePkg::tMemOp  memOpQ103H
);
    import corePkg::*;

    tWord       inst;
    tCtrl       ctrl;
    tOpcode     opcode;
    logic [2:0] funct3;
    tWord       immI, immS, immB, immU, immJ;
    tWord       aluIn1, aluIn2, aluOut;
    tAluOp      aluOp;
    logic       condMet;
    tWord       pcPlus4;
    tMemOp      memOpQ102H;
    tMemOp      memDataQ103H;
    tCtrl       ctrlQ103H;

    assign inst   = execQ102H.inst;
    assign ctrl   = execQ102H.ctrl;
    assign opcode = tOpcode'(inst[6:0]);
    assign funct3 = inst[14:12];

    ////////////////////
    // Immediates
    ////////////////////
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Operand select
    always_comb begin
        case ({ctrl.lui, ctrl.auiPc, ctrl.iTypeImm, ctrl.store})
            4'b1000: begin aluIn1 = '0;                aluIn2 = immU;              end
            4'b0100: begin aluIn1 = execQ102H.pc;      aluIn2 = immU;              end
            4'b0010: begin aluIn1 = execQ102H.rs1Data; aluIn2 = immI;              end
            4'b0001: begin aluIn1 = execQ102H.rs1Data; aluIn2 = immS;              end
            default: begin aluIn1 = execQ102H.rs1Data; aluIn2 = execQ102H.rs2Data; end
        endcase
    end

    // ALU op from funct3, funct7[5] only for OP and shift immediates
    always_comb begin
        aluOp = tAluOp'({1'b0, funct3});
        if (ctrl.lui || ctrl.auiPc || ctrl.memRd || ctrl.memWr) begin
            aluOp = AluAdd; // Address or upper immediate
        end else if ((opcode == OpOp) || ((opcode == OpOpImm) && (funct3[1:0] == 2'b01))) begin
            aluOp = tAluOp'({inst[30], funct3});
        end
    end

    aluUnit aluUnit_inst (.aluIn1(aluIn1), .aluIn2(aluIn2), .aluOp(aluOp), .aluOut(aluOut));

    branchCompare branchCompare_inst (
        .aluIn1(aluIn1), .aluIn2(aluIn2), .funct3(funct3), .branch(ctrl.branch), .condMet(condMet)
    );

    ////////////////////
    // Next PC
    ////////////////////
    assign pcPlus4 = execQ102H.pc + 32'd4;

    always_comb begin
        if (ctrl.jalr)      nextPcQ102H = {aluOut[31:1], 1'b0}; // rs1 + imm, LSB cleared
        else if (ctrl.jal)  nextPcQ102H = execQ102H.pc + immJ;
        else if (condMet)   nextPcQ102H = execQ102H.pc + immB;  // Taken branch
        else                nextPcQ102H = pcPlus4;
    end

    assign memOpQ102H = '{aluOut: aluOut, wrData: execQ102H.rs2Data, pcPlus4: pcPlus4,
                          funct3: funct3, rd: inst[11:7], ctrl: ctrl};

    // Q102H to Q103H
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) ctrlQ103H <= '0;
        else        ctrlQ103H <= ctrl;
    end

    always_ff @(posedge QClk) begin
        memDataQ103H <= memOpQ102H;
    end

    always_comb begin
        memOpQ103H      = memDataQ103H;
        memOpQ103H.ctrl = ctrlQ103H;
    end

endmodule

/* source/branchCompare.sv */
`timescale 1ns/1ps

module branchCompare (
    input  corePkg::tWord aluIn1,
    input  corePkg::tWord aluIn2,
    input  logic [2:0]    funct3,
    input  logic          branch,
    output logic          condMet
);
    logic isEq;
    logic isLtS;
    logic isLtU;

    assign isEq  = (aluIn1 == aluIn2);
    assign isLtS = ($signed(aluIn1) < $signed(aluIn2));
    assign isLtU = (aluIn1 < aluIn2);

    always_comb begin
        case ({branch, funct3})
            4'b1_000: condMet = isEq;   // BEQ
            4'b1_001: condMet = !isEq;  // BNE
            4'b1_100: condMet = isLtS;  // BLT
            4'b1_101: condMet = !isLtS; // BGE
            4'b1_110: condMet = isLtU;  // BLTU
            4'b1_111: condMet = !isLtU; // BGEU
            default:  condMet = 1'b0;   // Not a branch
        endcase
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  corePkg::tWord  aluIn1,
    input  corePkg::tWord  aluIn2,
    input  corePkg::tAluOp aluOp,
    output corePkg::tWord  aluOut
);
    import corePkg::*;

    logic [4:0] shamt;

    assign shamt = aluIn2[4:0]; // RV32I shift amount

    always_comb begin
        case (aluOp)
            // Adder
            AluAdd:  aluOut = aluIn1 + aluIn2;
            AluSub:  aluOut = aluIn1 - aluIn2;
            AluSlt:  aluOut = {31'b0, $signed(aluIn1) < $signed(aluIn2)};
            AluSltu: aluOut = {31'b0, aluIn1 < aluIn2};
            // Shifter
            AluSll:  aluOut = aluIn1 << shamt;
            AluSrl:  aluOut = aluIn1 >> shamt;
            AluSra:  aluOut = $signed(aluIn1) >>> shamt; // Sign fill
            // Bitwise
            AluXor:  aluOut = aluIn1 ^ aluIn2;
            AluOr:   aluOut = aluIn1 | aluIn2;
            AluAnd:  aluOut = aluIn1 & aluIn2;
            default: aluOut = '0;  // Unused encodings
        endcase
    end

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic               QClk,
    input  logic               arstN,
    input  corePkg::tThreadSel threadQ100H,
    input  corePkg::tRegAddr   rs1Q101H,
    input  corePkg::tRegAddr   rs2Q101H,
    input  corePkg::tRegWrite  regWriteQ104H,
    output corePkg::tWord      rs1DataQ101H,
    output corePkg::tWord      rs2DataQ101H
);
    import corePkg::*;

    tThreadSel                       threadQ101H;
    logic [$clog2(NumThreads)-1:0]   rdThread;
    logic [$clog2(NumThreads)-1:0]   wrThread;
    logic                            wrEn;
    tWord                            regBank [NumThreads][32]; // One bank per thread

    assign threadQ101H = {threadQ100H[0], threadQ100H[NumThreads-1:1]};

    // One-hot to bank index, Q104H thread is the Q100H thread
    always_comb begin
        rdThread = '0;
        wrThread = '0;
        for (int t = 0; t < NumThreads; t++) begin
            if (threadQ101H[t]) rdThread = t[$clog2(NumThreads)-1:0];
            if (threadQ100H[t]) wrThread = t[$clog2(NumThreads)-1:0];
        end
    end

    // x0 never written
    assign wrEn = arstN && regWriteQ104H.en && (regWriteQ104H.idx != '0);

    always_ff @(posedge QClk) begin
        if (wrEn) begin
            regBank[wrThread][regWriteQ104H.idx] <= regWriteQ104H.data;
        end
    end

    // x0 reads as zero regardless of bank contents
    assign rs1DataQ101H = (rs1Q101H == '0) ? '0 : regBank[rdThread][rs1Q101H];
    assign rs2DataQ101H = (rs2Q101H == '0) ? '0 : regBank[rdThread][rs2Q101H];

endmodule

/* source/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
    input  logic             QClk,
    input  logic             arstN,
    input  corePkg::tWord    instQ101H,
    input  corePkg::tWord    pcQ100H,
    input  corePkg::tWord    rs1DataQ101H,
    input  corePkg::tWord    rs2DataQ101H,
    output corePkg::tRegAddr rs1Q101H,
    output corePkg::tRegAddr rs2Q101H,
    output corePkg::tExecIn  execQ102H
);
    import corePkg::*;

    tWord   pcQ101H;
    tOpcode opcode;
    tCtrl   ctrlQ101H;
    tCtrl   ctrlQ102H;
    tExecIn execDataQ102H;

    // PC follows its instruction into decode
    always_ff @(posedge QClk) begin
        pcQ101H <= pcQ100H;
    end

    assign rs1Q101H = instQ101H[19:15]; // R/I/S/B
    assign rs2Q101H = instQ101H[24:20]; // R/S/B
    assign opcode   = tOpcode'(instQ101H[6:0]);

    ////////////////////
    // Control decode
    ////////////////////
    always_comb begin
        ctrlQ101H.jal      = (opcode == OpJal);
        ctrlQ101H.jalr     = (opcode == OpJalr);
        ctrlQ101H.branch   = (opcode == OpBranch);
        ctrlQ101H.iTypeImm = (opcode == OpOpImm) || (opcode == OpLoad) || (opcode == OpJalr);
        ctrlQ101H.lui      = (opcode == OpLui);
        ctrlQ101H.auiPc    = (opcode == OpAuiPc);
        ctrlQ101H.memRd    = (opcode == OpLoad);
        ctrlQ101H.memWr    = (opcode == OpStore);
        ctrlQ101H.store    = (opcode == OpStore);
        // Only opcodes with a destination write back
        ctrlQ101H.regWr    = (opcode == OpOp) || (opcode == OpOpImm) || (opcode == OpLoad) ||
                             (opcode == OpJal) || (opcode == OpJalr) ||
                             (opcode == OpLui) || (opcode == OpAuiPc);
        ctrlQ101H.memToReg = (opcode == OpLoad);
        ctrlQ101H.pcToReg  = (opcode == OpJal) || (opcode == OpJalr); // Link
    end

    // Q101H to Q102H
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            ctrlQ102H <= '0; // Empty pipe after reset
        end else begin
            ctrlQ102H <= ctrlQ101H;
        end
    end

    always_ff @(posedge QClk) begin
        execDataQ102H.pc      <= pcQ101H;
        execDataQ102H.inst    <= instQ101H;
        execDataQ102H.rs1Data <= rs1DataQ101H;
        execDataQ102H.rs2Data <= rs2DataQ101H;
        execDataQ102H.ctrl    <= ctrlQ101H;
    end

    always_comb begin
        execQ102H      = execDataQ102H;
        execQ102H.ctrl = ctrlQ102H; // Resettable copy wins
    end

endmodule

/* source/threadScheduler.sv */
`timescale 1ns/1ps

module threadScheduler #(
    parameter int ThreadPcStride = 256
) (
    input  logic               QClk,
    input  logic               arstN,
    input  corePkg::tWord      nextPcQ102H,
    output corePkg::tThreadSel threadQ100H,
    output corePkg::tWord      pcQ100H
);
    import corePkg::*;

    tThreadSel nextThreadQ100H;
    tThreadSel threadQ101H;
    tThreadSel threadQ102H;
    tThreadSel threadStarted;         // Set once a thread has fetched
    tWord      threadPc [NumThreads]; // One PC per thread

    ////////////////////
    // Thread ring
    ////////////////////
    assign nextThreadQ100H = {threadQ100H[NumThreads-2:0], threadQ100H[NumThreads-1]};

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            threadQ100H <= tThreadSel'(1); // Thread 0 fetches first
        end else begin
            threadQ100H <= nextThreadQ100H;
        end
    end

    // Later stages hold the threads that fetched earlier
    assign threadQ101H = {threadQ100H[0], threadQ100H[NumThreads-1:1]};
    assign threadQ102H = {threadQ101H[0], threadQ101H[NumThreads-1:1]};

    // Empty slots ahead of a thread's first fetch leave its PC alone
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            threadStarted <= '0;
        end else begin
            threadStarted <= threadStarted | threadQ100H;
        end
    end

    ////////////////////
    // Thread PCs
    ////////////////////
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            for (int t = 0; t < NumThreads; t++) begin
                threadPc[t] <= tWord'(t * ThreadPcStride); // Each thread owns a code window
            end
        end else begin
            for (int t = 0; t < NumThreads; t++) begin
                if (threadQ102H[t] && threadStarted[t]) begin
                    threadPc[t] <= nextPcQ102H; // Resolved in execute
                end
            end
        end
    end

    // One-hot fetch mux
    always_comb begin
        pcQ100H = '0;
        for (int t = 0; t < NumThreads; t++) begin
            if (threadQ100H[t]) begin
                pcQ100H = threadPc[t];
            end
        end
    end

endmodule

/* source/corePkg.sv */
package corePkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int NumThreads = 4;

    typedef logic [31:0]           tWord;      // Data, address and instruction word
    typedef logic [4:0]            tRegAddr;   // Register index x0..x31
    typedef logic [NumThreads-1:0] tThreadSel; // One-hot thread ring position

    // ADDI x0, x0, 0
    localparam tWord NopWord = 32'h0000_0013;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OpLui    = 7'b0110111,
        OpAuiPc  = 7'b0010111,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpBranch = 7'b1100011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpOpImm  = 7'b0010011,
        OpOp     = 7'b0110011
    } tOpcode;

    // Encoding is {funct7[5], funct3}
    typedef enum logic [3:0] {
        AluAdd  = 4'b0000,
        AluSub  = 4'b1000,
        AluSll  = 4'b0001,
        AluSlt  = 4'b0010,
        AluSltu = 4'b0011,
        AluXor  = 4'b0100,
        AluSrl  = 4'b0101,
        AluSra  = 4'b1101,
        AluOr   = 4'b0110,
        AluAnd  = 4'b0111
    } tAluOp;

    ////////////////////
    // Pipeline bundles
    ////////////////////
    typedef struct packed {
        logic jal;
        logic jalr;
        logic branch;
        logic iTypeImm;  // JALR, OPIMM, LOAD
        logic lui;
        logic auiPc;
        logic memRd;
        logic memWr;
        logic store;
        logic regWr;
        logic memToReg;
        logic pcToReg;   // Link value for JAL/JALR
    } tCtrl;

    typedef struct packed {
        tWord pc;
        tWord inst;
        tWord rs1Data;
        tWord rs2Data;
        tCtrl ctrl;
    } tExecIn;

    typedef struct packed {
        tWord       aluOut;  // Also the memory address
        tWord       wrData;
        tWord       pcPlus4;
        logic [2:0] funct3;
        tRegAddr    rd;
        tCtrl       ctrl;
    } tMemOp;

    typedef struct packed {
        tWord       addr;
        tWord       wrData;
        logic       rd;
        logic       wr;
        logic [3:0] byteEn;
    } tMemReq;

    typedef struct packed {
        logic    en;
        tRegAddr idx;
        tWord    data;
    } tRegWrite;

endpackage
